//--- verilog.f
+incdir+source
source/fdct_pkg.sv
source/block_loader.sv
source/fdct_row_stage.sv
source/fdct_col_stage.sv
source/fdct_core.sv
source/coeff_streamer.sv
source/fdct_top.sv
test/tb_fdct_top.sv

//--- Makefile
# Verilator simulation of the forward 4x4 transform subsystem
VERILATOR ?= verilator
TOP       ?= tb_fdct_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/fdct_input.txt
// Three lines per block: 16 source bytes, 16 reference bytes, then the
// 16 expected 12-bit coefficients, all in raster order (4*row + column)
// Zero residual
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
000 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// Flat residual +10
0a 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba ca da ea fa
00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0
050 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// Flat residual -20
05 15 25 35 45 55 65 75 85 95 a5 b5 c5 d5 e5 e0
19 29 39 49 59 69 79 89 99 a9 b9 c9 d9 e9 f9 f4
f60 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// Extreme residual +255
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
7f8 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// Extreme residual -255
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
808 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// Single pixel +16 at index 0
20 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
10 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
008 00b 008 005 00b 00e 00b 006 008 00a 008 004 005 006 005 003
// Single pixel -16 at index 0
10 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
20 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
ff8 ff6 ff8 ffc ff6 ff3 ff6 ffb ff8 ff6 ff8 ffc ffc ffb ffc ffe
// Top row +4, rest zero
54 54 54 54 33 33 33 33 33 33 33 33 33 33 33 33
50 50 50 50 33 33 33 33 33 33 33 33 33 33 33 33
008 001 000 000 00b 000 000 000 008 000 000 000 005 000 000 000

//--- test/tb_fdct_top.sv
// Testbench for the forward 4x4 transform subsystem
// Pixel pairs and expected coefficients are read from a data file.
// One process sends pairs over the input port with random gaps, a
// second one acknowledges and checks every output coefficient
`timescale 1ns/1ns

module tb_fdct_top;

    localparam int          CLK_PERIOD = 20;
    localparam int          MAX_BLK    = 32;
    localparam int          WORDS      = 48;        // 16 src, 16 ref, 16 expected
    localparam int          TIMEOUT    = 2000;      // Cycles allowed per wait
    localparam logic [15:0] EMPTY      = 16'hFFFF;  // Never a valid entry

    logic        clk;
    logic        rst_n;
    logic        in_req;
    logic [7:0]  src_pix;
    logic [7:0]  ref_pix;
    logic        in_ack;
    logic        out_req;
    logic [11:0] out_coef;
    logic        out_last;
    logic        out_ack;

    logic [15:0] vec_mem [MAX_BLK*WORDS];
    int          n_blk;
    int          err_cnt;
    int          chk_cnt;
    int          blk_rx;        // Blocks closed by out_last_o
    logic        ack_prev;
    logic [15:0] in_lfsr;
    logic [15:0] out_lfsr;

    fdct_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req_i   (in_req),
        .src_pix_i  (src_pix),
        .ref_pix_i  (ref_pix),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_coef_o (out_coef),
        .out_last_o (out_last),
        .out_ack_i  (out_ack)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Gap of 0 to 7 cycles from three fresh bits
    task automatic draw_gap(inout logic [15:0] st, output int gap);
        int k;
        gap = 0;
        for (k = 0; k < 3; k++) begin
            st  = lfsr_next(st);
            gap = (gap << 1) | int'(st[0]);
        end
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Checks %0d, errors %0d, blocks %0d of %0d",
                 chk_cnt, err_cnt, blk_rx, n_blk);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_for_ack(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (in_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (in_ack !== level) begin
            err_cnt++;
            $display("Timeout at %0t: in_ack_o never went to %0b", $time, level);
            end_run();
        end
    endtask

    task automatic poll_out_req(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (out_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (out_req !== level) begin
            err_cnt++;
            $display("Timeout at %0t: out_req_o never went to %0b", $time, level);
            end_run();
        end
    endtask

    task automatic check_idle_outputs();
        compare_value("in_ack_o", 16'(in_ack), 16'd0);
        compare_value("out_req_o", 16'(out_req), 16'd0);
        compare_value("out_last_o", 16'(out_last), 16'd0);
    endtask

    // ----------------------------------------
    // Input and output sides
    // ----------------------------------------
    task automatic send_blocks();
        int b;
        int i;
        int base;
        int gap;
        for (b = 0; b < n_blk; b++) begin
            base = b * WORDS;
            for (i = 0; i < 16; i++) begin
                @(posedge clk);
                src_pix <= vec_mem[base + i][7:0];
                ref_pix <= vec_mem[base + 16 + i][7:0];
                in_req  <= 1'b1;
                wait_for_ack(1'b1);
                @(posedge clk);
                in_req <= 1'b0;
                wait_for_ack(1'b0);
                draw_gap(in_lfsr, gap);
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    task automatic receive_blocks();
        int b;
        int i;
        int gap;
        for (b = 0; b < n_blk; b++) begin
            for (i = 0; i < 16; i++) begin
                poll_out_req(1'b1);
                compare_value($sformatf("out_coef_o[blk %0d idx %0d]", b, i),
                              {4'h0, out_coef}, vec_mem[b*WORDS + 32 + i]);
                compare_value($sformatf("out_last_o[blk %0d idx %0d]", b, i),
                              16'(out_last), (i == 15) ? 16'd1 : 16'd0);
                if (out_last) begin
                    blk_rx++;
                end
                draw_gap(out_lfsr, gap);    // Random ack delay
                repeat (gap) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                poll_out_req(1'b0);
                @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    endtask

    // Input port rules seen at the pins
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_ack && !ack_prev && !in_req) begin
                err_cnt++;
                $display("Error at %0t: in_ack_o rose while in_req_i was low", $time);
            end
            if (!in_ack && ack_prev && in_req) begin
                err_cnt++;
                $display("Error at %0t: in_ack_o fell while in_req_i was high", $time);
            end
        end
        ack_prev <= in_ack;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int   k;
        logic extra;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_req   = 1'b0;
        src_pix  = '0;
        ref_pix  = '0;
        out_ack  = 1'b0;
        err_cnt  = 0;
        chk_cnt  = 0;
        blk_rx   = 0;
        ack_prev = 1'b0;
        in_lfsr  = 16'd22;
        out_lfsr = 16'd22;

        for (k = 0; k < MAX_BLK*WORDS; k++) begin
            vec_mem[k] = EMPTY;
        end
        $readmemh("test/fdct_input.txt", vec_mem);
        n_blk = 0;
        while (n_blk < MAX_BLK && vec_mem[n_blk*WORDS] != EMPTY) begin
            n_blk++;
        end
        if (n_blk == 0) begin
            err_cnt++;
            $display("No blocks could be read from test/fdct_input.txt");
        end

        repeat (5) begin             // Held in reset
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();

        fork
            send_blocks();
            receive_blocks();
        join

        // Nothing may follow the last block
        extra = 1'b0;
        repeat (40) begin
            @(negedge clk);
            if (out_req) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            err_cnt++;
            $display("Error: out_req_o raised again after the last block");
        end
        compare_value("block count", 16'(blk_rx), 16'(n_blk));
        end_run();
    end

endmodule

//--- source/fdct_top.sv
// Forward 4x4 transform subsystem
// Input pairs over a four-phase port, loader, two-stage transform
// core and coefficient streamer on a second four-phase port
`timescale 1ns/1ns

module fdct_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_req_i,
    input  fdct_pkg::pix_t  src_pix_i,
    input  fdct_pkg::pix_t  ref_pix_i,
    output logic            in_ack_o,
    output logic            out_req_o,
    output fdct_pkg::coef_t out_coef_o,
    output logic            out_last_o,
    input  logic            out_ack_i
);
    import fdct_pkg::*;

    logic      blk_start;
    logic      blk_done;
    logic      buf_free;    // Streamer back-pressure to the loader
    pix_blk_t  src_blk;
    pix_blk_t  ref_blk;
    coef_blk_t coef_blk;

    block_loader i_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req_i    (in_req_i),
        .src_pix_i   (src_pix_i),
        .ref_pix_i   (ref_pix_i),
        .in_ack_o    (in_ack_o),
        .buf_free_i  (buf_free),
        .blk_start_o (blk_start),
        .src_blk_o   (src_blk),
        .ref_blk_o   (ref_blk)
    );

    fdct_core i_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_start_i (blk_start),
        .src_blk_i   (src_blk),
        .ref_blk_i   (ref_blk),
        .blk_done_o  (blk_done),
        .coef_blk_o  (coef_blk)
    );

    coeff_streamer i_streamer (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_done_i (blk_done),
        .coef_blk_i (coef_blk),
        .buf_free_o (buf_free),
        .out_req_o  (out_req_o),
        .out_coef_o (out_coef_o),
        .out_last_o (out_last_o),
        .out_ack_i  (out_ack_i)
    );

endmodule

//--- source/coeff_streamer.sv
// Coefficient streamer
// Buffers one finished block and sends its sixteen coefficients in
// raster order over a four-phase req/ack port, flagging the last.
// The buffer is reported free again once the last ack has dropped
`timescale 1ns/1ns
`include "fdct_settings.svh"

module coeff_streamer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                blk_done_i,
    input  fdct_pkg::coef_blk_t coef_blk_i,
    output logic                buf_free_o,
    output logic                out_req_o,
    output fdct_pkg::coef_t     out_coef_o,
    output logic                out_last_o,
    input  logic                out_ack_i
);
    import fdct_pkg::*;

    localparam idx_t LAST_IDX = idx_t'(`FDCT_NPIX - 1);

    send_state_t state_q;
    idx_t        idx_q;         // Coefficient on the port
    logic        req_q;
    logic        free_q;
    coef_blk_t   coef_buf_q;

    // ----------------------------------------
    // Output handshake FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TX_IDLE;
            idx_q   <= '0;
            req_q   <= 1'b0;
            free_q  <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (blk_done_i) begin
                        free_q  <= 1'b0;
                        req_q   <= 1'b1;
                        state_q <= TX_PRESENT;
                    end
                end
                TX_PRESENT: begin
                    if (out_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= TX_WAIT_DROP;
                    end
                end
                TX_WAIT_DROP: begin
                    if (!out_ack_i) begin
                        idx_q <= idx_q + 1'b1;    // Back to 0 after the last
                        if (idx_q == LAST_IDX) begin
                            free_q  <= 1'b1;
                            state_q <= TX_IDLE;
                        end else begin
                            req_q   <= 1'b1;
                            state_q <= TX_PRESENT;
                        end
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && blk_done_i) begin
            coef_buf_q <= coef_blk_i;
        end
    end

    assign buf_free_o = free_q;
    assign out_req_o  = req_q;
    assign out_coef_o = coef_buf_q[idx_q*$bits(coef_t) +: $bits(coef_t)];
    assign out_last_o = (idx_q == LAST_IDX);

    // Loader must hold a block back while the buffer is busy
    a_done_into_free: assert property (@(posedge clk) disable iff (!rst_n)
        blk_done_i |-> buf_free_o);

endmodule

//--- source/fdct_core.sv
// Forward 4x4 transform core
// Row stage then column stage, one register each, so a block
// started in one cycle is complete two cycles later. A new block
// may enter every cycle
`timescale 1ns/1ns

module fdct_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                blk_start_i,
    input  fdct_pkg::pix_blk_t  src_blk_i,
    input  fdct_pkg::pix_blk_t  ref_blk_i,
    output logic                blk_done_o,
    output fdct_pkg::coef_blk_t coef_blk_o
);
    import fdct_pkg::*;

    tmp_blk_t   tmp_blk;        // Row stage to column stage
    logic [1:0] vld_q;          // One bit per pipeline register

    // ----------------------------------------
    // Valid pipeline
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], blk_start_i};
        end
    end

    assign blk_done_o = vld_q[1];   // Coefficients valid in this cycle

    fdct_row_stage i_row (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_blk_i (src_blk_i),
        .ref_blk_i (ref_blk_i),
        .tmp_blk_o (tmp_blk)
    );

    fdct_col_stage i_col (
        .clk        (clk),
        .rst_n      (rst_n),
        .tmp_blk_i  (tmp_blk),
        .coef_blk_o (coef_blk_o)
    );

endmodule

//--- source/fdct_col_stage.sv
// Column stage of the forward 4x4 transform
// Runs the vertical four point butterfly on the row stage results
// with the codec rounding and bias terms, registering 12-bit
// coefficients in raster order
`timescale 1ns/1ns
`include "fdct_settings.svh"

module fdct_col_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  fdct_pkg::tmp_blk_t  tmp_blk_i,
    output fdct_pkg::coef_blk_t coef_blk_o
);
    import fdct_pkg::*;

    localparam int TW = $bits(tmp_t);
    localparam int CW = $bits(coef_t);

    genvar c, j;
    generate
        for (c = 0; c < `FDCT_BLOCK_SIZE; c++) begin : g_col
            tmp_t               t [`FDCT_BLOCK_SIZE];     // Column entries, top first
            logic signed [31:0] b0, b1, b2, b3;
            logic signed [31:0] e0, e1, e2, e3;
            logic signed [31:0] nz;
            coef_t              col_q [`FDCT_BLOCK_SIZE];

            for (j = 0; j < `FDCT_BLOCK_SIZE; j++) begin : g_ent
                localparam int POS = `FDCT_BLOCK_SIZE * j + c;
                assign t[j] = tmp_blk_i[POS*TW +: TW];
                assign coef_blk_o[POS*CW +: CW] = col_q[j];
            end

            assign b0 = 32'(t[0]) + 32'(t[3]);
            assign b1 = 32'(t[1]) + 32'(t[2]);
            assign b2 = 32'(t[1]) - 32'(t[2]);
            assign b3 = 32'(t[0]) - 32'(t[3]);

            assign nz = (b3 != 0) ? 32'sd1 : 32'sd0;  // Codec correction on coeff 4

            assign e0 = (b0 + b1 + 7) >>> 4;
            assign e1 = ((b2 * `FDCT_C0 + b3 * `FDCT_C1 + `FDCT_C4) >>> 16) + nz;
            assign e2 = (b0 - b1 + 7) >>> 4;
            assign e3 = (b3 * `FDCT_C0 - b2 * `FDCT_C1 + `FDCT_C5) >>> 16;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    col_q[0] <= '0;
                    col_q[1] <= '0;
                    col_q[2] <= '0;
                    col_q[3] <= '0;
                end else begin
                    col_q[0] <= e0[CW-1:0];
                    col_q[1] <= e1[CW-1:0];
                    col_q[2] <= e2[CW-1:0];
                    col_q[3] <= e3[CW-1:0];
                end
            end
        end
    endgenerate

endmodule

//--- source/fdct_row_stage.sv
// Row stage of the forward 4x4 transform
// Forms the residual src - ref of each row and runs the horizontal
// four point butterfly, registering 14-bit intermediates
`timescale 1ns/1ns
`include "fdct_settings.svh"

module fdct_row_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  fdct_pkg::pix_blk_t src_blk_i,
    input  fdct_pkg::pix_blk_t ref_blk_i,
    output fdct_pkg::tmp_blk_t tmp_blk_o
);
    import fdct_pkg::*;

    localparam int PW = $bits(pix_t);
    localparam int TW = $bits(tmp_t);

    genvar r, k;
    generate
        for (r = 0; r < `FDCT_BLOCK_SIZE; r++) begin : g_row
            localparam int BASE = `FDCT_BLOCK_SIZE * r;   // First pixel of the row

            logic signed [31:0] d [`FDCT_BLOCK_SIZE];     // Residual
            logic signed [31:0] a0, a1, a2, a3;
            logic signed [31:0] s0, s1, s2, s3;
            tmp_t               row_q [`FDCT_BLOCK_SIZE];

            for (k = 0; k < `FDCT_BLOCK_SIZE; k++) begin : g_pix
                assign d[k] = $signed(32'(src_blk_i[(BASE+k)*PW +: PW]))
                            - $signed(32'(ref_blk_i[(BASE+k)*PW +: PW]));
                assign tmp_blk_o[(BASE+k)*TW +: TW] = row_q[k];
            end

            assign a0 = d[0] + d[3];
            assign a1 = d[1] + d[2];
            assign a2 = d[1] - d[2];
            assign a3 = d[0] - d[3];

            // Even outputs scaled by 8, odd outputs rounded down by 512
            assign s0 = (a0 + a1) <<< 3;
            assign s1 = (a2 * `FDCT_C0 + a3 * `FDCT_C1 + `FDCT_C2) >>> 9;
            assign s2 = (a0 - a1) <<< 3;
            assign s3 = (a3 * `FDCT_C0 - a2 * `FDCT_C1 + `FDCT_C3) >>> 9;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    row_q[0] <= '0;
                    row_q[1] <= '0;
                    row_q[2] <= '0;
                    row_q[3] <= '0;
                end else begin
                    row_q[0] <= s0[TW-1:0];
                    row_q[1] <= s1[TW-1:0];
                    row_q[2] <= s2[TW-1:0];
                    row_q[3] <= s3[TW-1:0];
                end
            end
        end
    endgenerate

endmodule

//--- source/block_loader.sv
// Block loader
// Receives source/reference pixel pairs over a four-phase req/ack
// port, gathers sixteen of them in raster order and launches the
// block into the transform core once the output buffer is free
`timescale 1ns/1ns
`include "fdct_settings.svh"

module block_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_req_i,
    input  fdct_pkg::pix_t     src_pix_i,
    input  fdct_pkg::pix_t     ref_pix_i,
    output logic               in_ack_o,
    input  logic               buf_free_i,
    output logic               blk_start_o,
    output fdct_pkg::pix_blk_t src_blk_o,
    output fdct_pkg::pix_blk_t ref_blk_o
);
    import fdct_pkg::*;

    localparam idx_t LAST_IDX = idx_t'(`FDCT_NPIX - 1);

    load_state_t state_q;
    idx_t        idx_q;         // Slot of the pair being received
    logic        ack_q;
    pix_blk_t    src_blk_q;
    pix_blk_t    ref_blk_q;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LD_IDLE;
            idx_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                LD_IDLE: begin
                    if (in_req_i) begin
                        ack_q   <= 1'b1;
                        state_q <= LD_CAPTURE;
                    end
                end
                LD_CAPTURE: begin
                    if (!in_req_i) begin   // Sender has seen the ack
                        ack_q   <= 1'b0;
                        state_q <= LD_RELEASE;
                    end
                end
                LD_RELEASE: begin
                    idx_q   <= idx_q + 1'b1;  // Wraps to 0 after the last pair
                    state_q <= (idx_q == LAST_IDX) ? LD_LAUNCH : LD_IDLE;
                end
                LD_LAUNCH: begin
                    // No ack for the next block until the launch is done
                    if (buf_free_i) begin
                        state_q <= LD_IDLE;
                    end
                end
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // Pair latched when req is first seen
    always_ff @(posedge clk) begin
        if (state_q == LD_IDLE && in_req_i) begin
            src_blk_q[idx_q*$bits(pix_t) +: $bits(pix_t)] <= src_pix_i;
            ref_blk_q[idx_q*$bits(pix_t) +: $bits(pix_t)] <= ref_pix_i;
        end
    end

    assign in_ack_o    = ack_q;
    assign blk_start_o = (state_q == LD_LAUNCH) && buf_free_i;
    assign src_blk_o   = src_blk_q;   // Held until the next block overwrites
    assign ref_blk_o   = ref_blk_q;

    // Ack only rises while the request still stands
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack_o) |-> in_req_i);

endmodule

//--- source/fdct_pkg.sv
// Shared types of the forward transform subsystem
// Pixel, intermediate and coefficient vectors, packed blocks and
// the state encodings of the loader and streamer FSMs
`include "fdct_settings.svh"

package fdct_pkg;

    typedef logic        [`FDCT_PIX_W-1:0]  pix_t;   // Unsigned pixel
    typedef logic signed [`FDCT_COEF_W-1:0] coef_t;
    typedef logic signed [`FDCT_TMP_W-1:0]  tmp_t;   // Row stage result

    // Element i sits at bits W*i+W-1..W*i
    typedef logic [`FDCT_NPIX*`FDCT_PIX_W-1:0]  pix_blk_t;
    typedef logic [`FDCT_NPIX*`FDCT_TMP_W-1:0]  tmp_blk_t;
    typedef logic [`FDCT_NPIX*`FDCT_COEF_W-1:0] coef_blk_t;

    typedef logic [$clog2(`FDCT_NPIX)-1:0] idx_t;

    typedef enum logic [1:0] {
        LD_IDLE, LD_CAPTURE, LD_RELEASE, LD_LAUNCH
    } load_state_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_PRESENT, TX_WAIT_DROP
    } send_state_t;

endpackage

//--- source/fdct_settings.svh
// Fixed sizes and constants of the VP8 forward 4x4 transform
// Widths of pixels, row intermediates and output coefficients
`ifndef FDCT_SETTINGS_SVH
`define FDCT_SETTINGS_SVH

// Data widths
`define FDCT_PIX_W       8
`define FDCT_COEF_W      12
`define FDCT_TMP_W       14      // Row stage output

// Block geometry
// The butterflies are written for four points only
`define FDCT_BLOCK_SIZE  4
`define FDCT_NPIX        16

// Butterfly multipliers and rounding biases
`define FDCT_C0          2217
`define FDCT_C1          5352
`define FDCT_C2          1812
`define FDCT_C3          937
`define FDCT_C4          12000
`define FDCT_C5          51000

`endif
